/* common/scaler_pkg.sv */
`default_nettype none

package scaler_pkg;

    // Source image geometry
    localparam int SRC_WIDTH  = 160;
    localparam int SRC_HEIGHT = 120;

    // Factor used by decimation, replication and averaging
    localparam int SCALE = 2;

    // Edges from an engine's address update to the edge that samples the data
    localparam int READ_LATENCY = 2;

    typedef logic [18:0] addr_t;
    typedef logic [7:0]  pixel_t;

    // Other selector codes leave the scaler idle
    typedef enum logic [3:0] {
        MODE_REPLICATE = 4'd0,
        MODE_DECIMATE  = 4'd1,
        MODE_AVERAGE   = 4'd3,
        MODE_COPY      = 4'd4
    } mode_t;

endpackage

`default_nettype wire

/* engines/stride_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module stride_engine import scaler_pkg::*; #(
    parameter int STRIDE = 1
) (
    input  wire logic   clk,
    input  wire logic   reset,
    input  wire logic   run,
    output addr_t       rom_addr,
    input  wire pixel_t rom_data,
    output addr_t       ram_wraddr,
    output pixel_t      ram_data,
    output logic        ram_wren,
    output logic        done
);

    localparam addr_t LAST_COL = addr_t'(SRC_WIDTH - STRIDE);
    localparam addr_t COL_STEP = addr_t'(STRIDE);
    localparam addr_t ROW_STEP = addr_t'(STRIDE * SRC_WIDTH);
    localparam addr_t LAST_ROW = addr_t'((SRC_HEIGHT - STRIDE) * SRC_WIDTH);

    addr_t                   col;
    addr_t                   row_base;
    addr_t                   out_addr;
    logic                    finished;
    logic [READ_LATENCY-1:0] valid_pipe;
    addr_t                   addr_pipe [READ_LATENCY];

    // Output address rides beside the read until its data returns
    always_ff @(posedge clk) begin
        addr_pipe[0] <= out_addr;
        for (int i = 1; i < READ_LATENCY; i++) begin
            addr_pipe[i] <= addr_pipe[i-1];
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            col        <= '0;
            row_base   <= '0;
            out_addr   <= '0;
            finished   <= 1'b0;
            valid_pipe <= '0;
            rom_addr   <= '0;
            ram_wraddr <= '0;
            ram_data   <= '0;
            ram_wren   <= 1'b0;
            done       <= 1'b0;
        end else if (!run) begin
            col        <= '0;
            row_base   <= '0;
            out_addr   <= '0;
            finished   <= 1'b0;
            valid_pipe <= '0;
            rom_addr   <= '0;
            ram_wraddr <= '0;
            ram_data   <= '0;
            ram_wren   <= 1'b0;
            done       <= 1'b0;
        end else begin
            valid_pipe <= {valid_pipe[READ_LATENCY-2:0], !finished};

            if (!finished) begin
                rom_addr <= row_base + col;
                out_addr <= out_addr + 1'b1;
                if (col == LAST_COL) begin
                    col <= '0;
                    if (row_base == LAST_ROW) begin
                        finished <= 1'b1;
                    end else begin
                        row_base <= row_base + ROW_STEP;
                    end
                end else begin
                    col <= col + COL_STEP;
                end
            end

            // Write stage samples the returning pixel
            ram_wren <= valid_pipe[READ_LATENCY-1];
            if (valid_pipe[READ_LATENCY-1]) begin
                ram_wraddr <= addr_pipe[READ_LATENCY-1];
                ram_data   <= rom_data;
            end

            done <= finished && !(|valid_pipe);
        end
    end

endmodule

`default_nettype wire

/* engines/replicate_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module replicate_engine import scaler_pkg::*; (
    input  wire logic   clk,
    input  wire logic   reset,
    input  wire logic   run,
    output addr_t       rom_addr,
    input  wire pixel_t rom_data,
    output addr_t       ram_wraddr,
    output pixel_t      ram_data,
    output logic        ram_wren,
    output logic        done
);

    localparam int    OUT_W    = SRC_WIDTH * SCALE;
    localparam int    OUT_H    = SRC_HEIGHT * SCALE;
    localparam addr_t LAST_X   = addr_t'(OUT_W - 1);
    localparam addr_t SRC_LINE = addr_t'(SRC_WIDTH);

    addr_t                   out_x;
    logic [8:0]              out_y;
    addr_t                   src_row_base;
    addr_t                   out_addr;
    logic                    finished;
    logic [READ_LATENCY-1:0] valid_pipe;
    addr_t                   addr_pipe [READ_LATENCY];

    always_ff @(posedge clk) begin
        addr_pipe[0] <= out_addr;
        for (int i = 1; i < READ_LATENCY; i++) begin
            addr_pipe[i] <= addr_pipe[i-1];
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            out_x        <= '0;
            out_y        <= '0;
            src_row_base <= '0;
            out_addr     <= '0;
            finished     <= 1'b0;
            valid_pipe   <= '0;
            rom_addr     <= '0;
            ram_wraddr   <= '0;
            ram_data     <= '0;
            ram_wren     <= 1'b0;
            done         <= 1'b0;
        end else if (!run) begin
            out_x        <= '0;
            out_y        <= '0;
            src_row_base <= '0;
            out_addr     <= '0;
            finished     <= 1'b0;
            valid_pipe   <= '0;
            rom_addr     <= '0;
            ram_wraddr   <= '0;
            ram_data     <= '0;
            ram_wren     <= 1'b0;
            done         <= 1'b0;
        end else begin
            valid_pipe <= {valid_pipe[READ_LATENCY-2:0], !finished};

            // One read per output pixel, repeated source pixels included
            if (!finished) begin
                rom_addr <= src_row_base + (out_x >> 1);
                out_addr <= out_addr + 1'b1;
                if (out_x == LAST_X) begin
                    out_x <= '0;
                    if (out_y == 9'(OUT_H - 1)) begin
                        finished <= 1'b1;
                    end else begin
                        out_y <= out_y + 1'b1;
                        // Odd output row closes a source row
                        if (out_y[0]) begin
                            src_row_base <= src_row_base + SRC_LINE;
                        end
                    end
                end else begin
                    out_x <= out_x + 1'b1;
                end
            end

            ram_wren <= valid_pipe[READ_LATENCY-1];
            if (valid_pipe[READ_LATENCY-1]) begin
                ram_wraddr <= addr_pipe[READ_LATENCY-1];
                ram_data   <= rom_data;
            end

            done <= finished && !(|valid_pipe);
        end
    end

endmodule

`default_nettype wire

/* engines/average_engine.sv */
`timescale 1ns/1ps
`default_nettype none

module average_engine import scaler_pkg::*; (
    input  wire logic   clk,
    input  wire logic   reset,
    input  wire logic   run,
    output addr_t       rom_addr,
    input  wire pixel_t rom_data,
    output addr_t       ram_wraddr,
    output pixel_t      ram_data,
    output logic        ram_wren,
    output logic        done
);

    localparam addr_t LAST_COL = addr_t'(SRC_WIDTH - SCALE);
    localparam addr_t COL_STEP = addr_t'(SCALE);
    localparam addr_t ROW_STEP = addr_t'(SCALE * SRC_WIDTH);
    localparam addr_t LAST_ROW = addr_t'((SRC_HEIGHT - SCALE) * SRC_WIDTH);
    localparam addr_t SRC_LINE = addr_t'(SRC_WIDTH);

    addr_t                   blk_col;
    addr_t                   row_base;
    logic [1:0]              sub;
    addr_t                   sub_offset;
    addr_t                   out_addr;
    logic                    finished;
    logic [READ_LATENCY-1:0] valid_pipe;
    addr_t                   addr_pipe [READ_LATENCY];
    logic [1:0]              sub_pipe [READ_LATENCY];
    logic [9:0]              acc;
    logic [9:0]              block_sum;

    // Block order is top-left, top-right, bottom-left, bottom-right
    assign sub_offset = (sub[1] ? SRC_LINE : '0) + addr_t'(sub[0]);
    assign block_sum  = acc + {2'b00, rom_data};

    // Block tag travels with each read
    always_ff @(posedge clk) begin
        addr_pipe[0] <= out_addr;
        sub_pipe[0]  <= sub;
        for (int i = 1; i < READ_LATENCY; i++) begin
            addr_pipe[i] <= addr_pipe[i-1];
            sub_pipe[i]  <= sub_pipe[i-1];
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            blk_col    <= '0;
            row_base   <= '0;
            sub        <= '0;
            out_addr   <= '0;
            finished   <= 1'b0;
            valid_pipe <= '0;
            acc        <= '0;
            rom_addr   <= '0;
            ram_wraddr <= '0;
            ram_data   <= '0;
            ram_wren   <= 1'b0;
            done       <= 1'b0;
        end else if (!run) begin
            blk_col    <= '0;
            row_base   <= '0;
            sub        <= '0;
            out_addr   <= '0;
            finished   <= 1'b0;
            valid_pipe <= '0;
            acc        <= '0;
            rom_addr   <= '0;
            ram_wraddr <= '0;
            ram_data   <= '0;
            ram_wren   <= 1'b0;
            done       <= 1'b0;
        end else begin
            valid_pipe <= {valid_pipe[READ_LATENCY-2:0], !finished};

            if (!finished) begin
                rom_addr <= row_base + blk_col + sub_offset;
                sub      <= sub + 1'b1;
                if (sub == 2'd3) begin
                    out_addr <= out_addr + 1'b1;
                    if (blk_col == LAST_COL) begin
                        blk_col <= '0;
                        if (row_base == LAST_ROW) begin
                            finished <= 1'b1;
                        end else begin
                            row_base <= row_base + ROW_STEP;
                        end
                    end else begin
                        blk_col <= blk_col + COL_STEP;
                    end
                end
            end

            // First pixel of a block restarts the sum
            if (valid_pipe[READ_LATENCY-1]) begin
                if (sub_pipe[READ_LATENCY-1] == 2'd0) begin
                    acc <= {2'b00, rom_data};
                end else begin
                    acc <= block_sum;
                end
            end

            ram_wren <= valid_pipe[READ_LATENCY-1] && (sub_pipe[READ_LATENCY-1] == 2'd3);
            if (valid_pipe[READ_LATENCY-1] && (sub_pipe[READ_LATENCY-1] == 2'd3)) begin
                ram_wraddr <= addr_pipe[READ_LATENCY-1];
                ram_data   <= block_sum[9:2];
            end

            done <= finished && !(|valid_pipe);
        end
    end

endmodule

`default_nettype wire

/* logic/mode_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module mode_arbiter import scaler_pkg::*; (
    input  wire logic   clk,
    input  wire logic   reset,
    input  wire mode_t  mode,

    output logic        copy_run,
    input  wire addr_t  copy_rom_addr,
    input  wire addr_t  copy_ram_wraddr,
    input  wire pixel_t copy_ram_data,
    input  wire logic   copy_ram_wren,
    input  wire logic   copy_done,

    output logic        dec_run,
    input  wire addr_t  dec_rom_addr,
    input  wire addr_t  dec_ram_wraddr,
    input  wire pixel_t dec_ram_data,
    input  wire logic   dec_ram_wren,
    input  wire logic   dec_done,

    output logic        rep_run,
    input  wire addr_t  rep_rom_addr,
    input  wire addr_t  rep_ram_wraddr,
    input  wire pixel_t rep_ram_data,
    input  wire logic   rep_ram_wren,
    input  wire logic   rep_done,

    output logic        avg_run,
    input  wire addr_t  avg_rom_addr,
    input  wire addr_t  avg_ram_wraddr,
    input  wire pixel_t avg_ram_data,
    input  wire logic   avg_ram_wren,
    input  wire logic   avg_done,

    output addr_t       rom_addr,
    output addr_t       ram_wraddr,
    output pixel_t      ram_data,
    output logic        ram_wren,
    output logic        done
);

    typedef enum logic [2:0] {
        GRANT_IDLE,
        GRANT_COPY,
        GRANT_DEC,
        GRANT_REP,
        GRANT_AVG
    } grant_t;

    grant_t grant;
    grant_t requested;
    addr_t  sel_wraddr;
    pixel_t sel_data;
    logic   sel_wren;
    logic   sel_done;

    always_comb begin
        case (mode)
            MODE_COPY:      requested = GRANT_COPY;
            MODE_DECIMATE:  requested = GRANT_DEC;
            MODE_REPLICATE: requested = GRANT_REP;
            MODE_AVERAGE:   requested = GRANT_AVG;
            default:        requested = GRANT_IDLE;
        endcase
    end

    assign copy_run = (grant == GRANT_COPY);
    assign dec_run  = (grant == GRANT_DEC);
    assign rep_run  = (grant == GRANT_REP);
    assign avg_run  = (grant == GRANT_AVG);

    // Read address passes straight through, write side is selected for registering
    always_comb begin
        rom_addr   = '0;
        sel_wraddr = '0;
        sel_data   = '0;
        sel_wren   = 1'b0;
        sel_done   = 1'b0;
        case (grant)
            GRANT_COPY: begin
                rom_addr   = copy_rom_addr;
                sel_wraddr = copy_ram_wraddr;
                sel_data   = copy_ram_data;
                sel_wren   = copy_ram_wren;
                sel_done   = copy_done;
            end
            GRANT_DEC: begin
                rom_addr   = dec_rom_addr;
                sel_wraddr = dec_ram_wraddr;
                sel_data   = dec_ram_data;
                sel_wren   = dec_ram_wren;
                sel_done   = dec_done;
            end
            GRANT_REP: begin
                rom_addr   = rep_rom_addr;
                sel_wraddr = rep_ram_wraddr;
                sel_data   = rep_ram_data;
                sel_wren   = rep_ram_wren;
                sel_done   = rep_done;
            end
            GRANT_AVG: begin
                rom_addr   = avg_rom_addr;
                sel_wraddr = avg_ram_wraddr;
                sel_data   = avg_ram_data;
                sel_wren   = avg_ram_wren;
                sel_done   = avg_done;
            end
            default: begin
                rom_addr = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        ram_wraddr <= sel_wraddr;
        ram_data   <= sel_data;
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            grant    <= GRANT_IDLE;
            ram_wren <= 1'b0;
            done     <= 1'b0;
        end else if (grant == GRANT_IDLE) begin
            grant    <= requested;
            ram_wren <= 1'b0;
            done     <= 1'b0;
        end else if (requested != grant) begin
            // Mode changed mid-run, abort and wait for a fresh start
            grant    <= GRANT_IDLE;
            ram_wren <= 1'b0;
            done     <= 1'b0;
        end else begin
            ram_wren <= sel_wren;
            done     <= sel_done;
        end
    end

endmodule

`default_nettype wire

/* logic/image_scaler.sv */
`timescale 1ns/1ps
`default_nettype none

module image_scaler import scaler_pkg::*; (
    input  wire logic   clk,
    input  wire logic   reset,
    input  wire mode_t  mode,
    output addr_t       rom_addr,
    input  wire pixel_t rom_data,
    output addr_t       ram_wraddr,
    output pixel_t      ram_data,
    output logic        ram_wren,
    output logic        done
);

    logic   copy_run;
    addr_t  copy_rom_addr;
    addr_t  copy_ram_wraddr;
    pixel_t copy_ram_data;
    logic   copy_ram_wren;
    logic   copy_done;

    logic   dec_run;
    addr_t  dec_rom_addr;
    addr_t  dec_ram_wraddr;
    pixel_t dec_ram_data;
    logic   dec_ram_wren;
    logic   dec_done;

    logic   rep_run;
    addr_t  rep_rom_addr;
    addr_t  rep_ram_wraddr;
    pixel_t rep_ram_data;
    logic   rep_ram_wren;
    logic   rep_done;

    logic   avg_run;
    addr_t  avg_rom_addr;
    addr_t  avg_ram_wraddr;
    pixel_t avg_ram_data;
    logic   avg_ram_wren;
    logic   avg_done;

    // Copy is a stride of one
    stride_engine #(.STRIDE(1)) copy_i (
        .clk        (clk),
        .reset      (reset),
        .run        (copy_run),
        .rom_addr   (copy_rom_addr),
        .rom_data   (rom_data),
        .ram_wraddr (copy_ram_wraddr),
        .ram_data   (copy_ram_data),
        .ram_wren   (copy_ram_wren),
        .done       (copy_done)
    );

    stride_engine #(.STRIDE(SCALE)) dec_i (
        .clk        (clk),
        .reset      (reset),
        .run        (dec_run),
        .rom_addr   (dec_rom_addr),
        .rom_data   (rom_data),
        .ram_wraddr (dec_ram_wraddr),
        .ram_data   (dec_ram_data),
        .ram_wren   (dec_ram_wren),
        .done       (dec_done)
    );

    replicate_engine rep_i (
        .clk        (clk),
        .reset      (reset),
        .run        (rep_run),
        .rom_addr   (rep_rom_addr),
        .rom_data   (rom_data),
        .ram_wraddr (rep_ram_wraddr),
        .ram_data   (rep_ram_data),
        .ram_wren   (rep_ram_wren),
        .done       (rep_done)
    );

    average_engine avg_i (
        .clk        (clk),
        .reset      (reset),
        .run        (avg_run),
        .rom_addr   (avg_rom_addr),
        .rom_data   (rom_data),
        .ram_wraddr (avg_ram_wraddr),
        .ram_data   (avg_ram_data),
        .ram_wren   (avg_ram_wren),
        .done       (avg_done)
    );

    mode_arbiter arb_i (
        .clk             (clk),
        .reset           (reset),
        .mode            (mode),
        .copy_run        (copy_run),
        .copy_rom_addr   (copy_rom_addr),
        .copy_ram_wraddr (copy_ram_wraddr),
        .copy_ram_data   (copy_ram_data),
        .copy_ram_wren   (copy_ram_wren),
        .copy_done       (copy_done),
        .dec_run         (dec_run),
        .dec_rom_addr    (dec_rom_addr),
        .dec_ram_wraddr  (dec_ram_wraddr),
        .dec_ram_data    (dec_ram_data),
        .dec_ram_wren    (dec_ram_wren),
        .dec_done        (dec_done),
        .rep_run         (rep_run),
        .rep_rom_addr    (rep_rom_addr),
        .rep_ram_wraddr  (rep_ram_wraddr),
        .rep_ram_data    (rep_ram_data),
        .rep_ram_wren    (rep_ram_wren),
        .rep_done        (rep_done),
        .avg_run         (avg_run),
        .avg_rom_addr    (avg_rom_addr),
        .avg_ram_wraddr  (avg_ram_wraddr),
        .avg_ram_data    (avg_ram_data),
        .avg_ram_wren    (avg_ram_wren),
        .avg_done        (avg_done),
        .rom_addr        (rom_addr),
        .ram_wraddr      (ram_wraddr),
        .ram_data        (ram_data),
        .ram_wren        (ram_wren),
        .done            (done)
    );

endmodule

`default_nettype wire

/* bench/scaler_checks.svh */
`ifndef SCALER_CHECKS_SVH
`define SCALER_CHECKS_SVH

// Fibonacci LFSR with taps 32, 22, 2 and 1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
endfunction

function automatic int output_pixels(input mode_t m);
    case (m)
        MODE_COPY:      return SRC_WIDTH * SRC_HEIGHT;
        MODE_REPLICATE: return SRC_WIDTH * SRC_HEIGHT * SCALE * SCALE;
        MODE_DECIMATE:  return (SRC_WIDTH / SCALE) * (SRC_HEIGHT / SCALE);
        MODE_AVERAGE:   return (SRC_WIDTH / SCALE) * (SRC_HEIGHT / SCALE);
        default:        return 0;
    endcase
endfunction

// Expected output pixel at output address a
function automatic pixel_t expected_pixel(input mode_t m, input addr_t a);
    int out_w;
    int x;
    int y;
    int sum;
    sum = 0;
    case (m)
        MODE_COPY: begin
            return rom_mem[int'(a)];
        end
        MODE_DECIMATE: begin
            out_w = SRC_WIDTH / SCALE;
            x = (int'(a) % out_w) * SCALE;
            y = (int'(a) / out_w) * SCALE;
            return rom_mem[y * SRC_WIDTH + x];
        end
        MODE_REPLICATE: begin
            out_w = SRC_WIDTH * SCALE;
            x = (int'(a) % out_w) / SCALE;
            y = (int'(a) / out_w) / SCALE;
            return rom_mem[y * SRC_WIDTH + x];
        end
        MODE_AVERAGE: begin
            out_w = SRC_WIDTH / SCALE;
            x = (int'(a) % out_w) * SCALE;
            y = (int'(a) / out_w) * SCALE;
            for (int dy = 0; dy < SCALE; dy++) begin
                for (int dx = 0; dx < SCALE; dx++) begin
                    sum = sum + int'(rom_mem[(y + dy) * SRC_WIDTH + x + dx]);
                end
            end
            // Integer division rounds the mean down
            return pixel_t'(sum / (SCALE * SCALE));
        end
        default: begin
            return '0;
        end
    endcase
endfunction

task automatic check_pixel(input string test, input addr_t addr, input pixel_t expected,
                           input pixel_t actual);
    if (actual !== expected) begin
        value_errors++;
        $display("FAIL %s at address %0d: expected %02h, actual %02h",
                 test, addr, expected, actual);
    end
endtask

task automatic check_addr_range(input string test, input addr_t addr, input int limit);
    if (int'(addr) >= limit) begin
        other_errors++;
        $display("%s: address %0d lies outside the %0d-pixel range",
                 test, addr, limit);
    end
endtask

task automatic check_count(input string test, input int expected, input int actual);
    if (actual != expected) begin
        value_errors++;
        $display("FAIL %s: expected %0d, actual %0d", test, expected, actual);
    end
endtask

task automatic check_flag(input string test, input logic expected, input logic actual);
    if (actual !== expected) begin
        value_errors++;
        $display("FAIL %s: expected %b, actual %b", test, expected, actual);
    end
endtask

`endif

/* bench/image_scaler_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module image_scaler_tb import scaler_pkg::*; ();

    localparam int          SRC_PIXELS = SRC_WIDTH * SRC_HEIGHT;
    localparam int          MAX_PIXELS = SRC_PIXELS * SCALE * SCALE;
    localparam logic [31:0] LFSR_SEED  = 32'hc583_e102;
    localparam mode_t       IDLE_MODE  = mode_t'(4'd2);

    // Copy, decimate, replicate, average (four cycles per output), aborted copy, decimate
    localparam int WATCHDOG_CYCLES = 2 * (SRC_PIXELS + SRC_PIXELS / 4 + MAX_PIXELS
        + SRC_PIXELS + SRC_PIXELS + SRC_PIXELS / 4 + 1000);

    logic   clk;
    logic   reset;
    mode_t  mode;
    addr_t  rom_addr;
    pixel_t rom_data;
    addr_t  ram_wraddr;
    pixel_t ram_data;
    logic   ram_wren;
    logic   done;

    pixel_t rom_mem [SRC_PIXELS];
    pixel_t frame_mem [MAX_PIXELS];
    int     write_count [MAX_PIXELS];
    int     total_writes;
    int     out_limit;
    int     value_errors;
    int     other_errors;

    `include "scaler_checks.svh"

    image_scaler dut_i (
        .clk        (clk),
        .reset      (reset),
        .mode       (mode),
        .rom_addr   (rom_addr),
        .rom_data   (rom_data),
        .ram_wraddr (ram_wraddr),
        .ram_data   (ram_data),
        .ram_wren   (ram_wren),
        .done       (done)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Synchronous image memory
    always @(posedge clk) begin
        check_addr_range("image read", rom_addr, SRC_PIXELS);
        rom_data <= rom_mem[rom_addr];
    end

    // Frame memory records writes once the bus has settled
    always @(negedge clk) begin
        if (ram_wren) begin
            total_writes = total_writes + 1;
            check_addr_range("frame write", ram_wraddr, out_limit);
            if (int'(ram_wraddr) < out_limit) begin
                frame_mem[ram_wraddr]   = ram_data;
                write_count[ram_wraddr] = write_count[ram_wraddr] + 1;
            end
        end
    end

    task automatic clear_frame(input mode_t m);
        for (int a = 0; a < MAX_PIXELS; a++) begin
            frame_mem[a]   = '0;
            write_count[a] = 0;
        end
        total_writes = 0;
        out_limit    = output_pixels(m);
    endtask

    task automatic set_idle();
        @(negedge clk);
        mode = IDLE_MODE;
        repeat (3) @(negedge clk);
    endtask

    task automatic verify_frame(input mode_t m, input string name);
        for (int a = 0; a < output_pixels(m); a++) begin
            check_count({name, " writes per address"}, 1, write_count[a]);
            check_pixel(name, addr_t'(a), expected_pixel(m, addr_t'(a)), frame_mem[a]);
        end
    endtask

    task automatic run_mode(input mode_t m, input string name);
        int latency;
        int first_write;
        // Averaging writes only after the fourth read of a block
        first_write = READ_LATENCY + 3 + ((m == MODE_AVERAGE) ? SCALE * SCALE - 1 : 0);
        clear_frame(m);
        @(negedge clk);
        mode    = m;
        latency = 0;
        do begin
            @(negedge clk);
            latency++;
        end while (!ram_wren);
        check_count({name, " first write latency"}, first_write, latency);
        while (!done) begin
            @(negedge clk);
        end
        check_count({name, " write total"}, output_pixels(m), total_writes);
        verify_frame(m, name);
        repeat (5) begin
            @(negedge clk);
            check_flag({name, " done held"}, 1'b1, done);
        end
        set_idle();
    endtask

    task automatic abort_and_restart();
        int writes_at_stop;
        clear_frame(MODE_COPY);
        @(negedge clk);
        mode = MODE_COPY;
        while (total_writes < SRC_PIXELS / 4) begin
            @(negedge clk);
        end
        mode = IDLE_MODE;
        repeat (2) @(negedge clk);
        writes_at_stop = total_writes;
        repeat (200) begin
            @(negedge clk);
            check_flag("abort write enable", 1'b0, ram_wren);
            check_flag("abort done", 1'b0, done);
        end
        check_count("abort writes after stop", writes_at_stop, total_writes);
        run_mode(MODE_DECIMATE, "restart decimate");
    endtask

    initial begin
        logic [31:0] state;
        pixel_t      pix;
        reset        = 1'b0;
        mode         = IDLE_MODE;
        rom_data     = '0;
        value_errors = 0;
        other_errors = 0;
        state        = LFSR_SEED;
        pix          = '0;
        for (int i = 0; i < SRC_PIXELS; i++) begin
            for (int b = 0; b < 8; b++) begin
                state = lfsr_next(state);
                pix   = {pix[6:0], state[0]};
            end
            rom_mem[i] = pix;
        end
        clear_frame(IDLE_MODE);
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b1;

        repeat (100) begin
            @(negedge clk);
            check_flag("idle write enable", 1'b0, ram_wren);
            check_flag("idle done", 1'b0, done);
        end
        run_mode(MODE_COPY, "copy");
        run_mode(MODE_DECIMATE, "decimate");
        run_mode(MODE_REPLICATE, "replicate");
        run_mode(MODE_AVERAGE, "average");
        abort_and_restart();

        $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles before the tests completed", WATCHDOG_CYCLES);
        $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
+incdir+bench
common/scaler_pkg.sv
engines/stride_engine.sv
engines/replicate_engine.sv
engines/average_engine.sv
logic/mode_arbiter.sv
logic/image_scaler.sv
bench/image_scaler_tb.sv
